//--- design/jclk_bus_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register bus arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module jclk_bus_arbiter (
	input logic sys_clk,
	input logic resetl,
	input jclk_pkg::reg_wr_t host_wr,
	input jclk_pkg::reg_wr_t dsp_wr,
	output logic host_gnt,
	output logic dsp_gnt,
	output jclk_pkg::reg_wr_t bus_wr
);

	jclk_pkg::arb_state_t state;
	jclk_pkg::arb_state_t state_nxt;
	logic host_req;
	logic dsp_req;

	// A master granted in this cycle still shows valid at the next edge
	// Mask it so one request never gets two grants
	assign host_req = host_wr.valid && (state != jclk_pkg::ARB_HOST);
	assign dsp_req = dsp_wr.valid && (state != jclk_pkg::ARB_DSP);

	// Fixed priority, host first
	// A held DSP request wins once the host is masked or idle
	always_comb begin
		if (host_req) begin
			state_nxt = jclk_pkg::ARB_HOST;
		end else if (dsp_req) begin
			state_nxt = jclk_pkg::ARB_DSP;
		end else begin
			state_nxt = jclk_pkg::ARB_IDLE;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= jclk_pkg::ARB_IDLE;
			bus_wr.valid <= 1'b0;
		end else begin
			state <= state_nxt;
			bus_wr.valid <= (state_nxt != jclk_pkg::ARB_IDLE);
		end
		// Winner's address and data, one bus cycle
		if (state_nxt == jclk_pkg::ARB_DSP) begin
			bus_wr.addr <= dsp_wr.addr;
			bus_wr.data <= dsp_wr.data;
		end else begin
			bus_wr.addr <= host_wr.addr;
			bus_wr.data <= host_wr.data;
		end
	end

	// Grant pulses line up with the forwarded bus cycle
	assign host_gnt = (state == jclk_pkg::ARB_HOST);
	assign dsp_gnt = (state == jclk_pkg::ARB_DSP);

endmodule

//--- design/jclk_cfg_seq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration and CPU clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module jclk_cfg_seq (
	input logic sys_clk,
	input logic resetl,
	input logic pclkosc,
	input logic cfg_divide,
	output logic cfgw,
	output logic cfgen,
	output logic pclkout,
	output logic cpuclk
);

	logic osc_q;
	logic osc_qq;
	logic osc_rise;
	logic pout_q;
	logic pout_qq;
	logic pout_rise;
	logic divide;
	logic pclk2;

	// Two sample stages on the oscillator pin
	// Edge acts one cycle after it is first seen high
	always_ff @(posedge sys_clk) begin
		osc_q <= pclkosc;
		osc_qq <= osc_q;
	end
	assign osc_rise = osc_q & ~osc_qq;

	// Reset shifted through two oscillator edges
	// cfgw opens on the first edge, cfgen follows on the second
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cfgw <= 1'b0;
			cfgen <= 1'b0;
		end else if (osc_rise) begin
			cfgw <= resetl;
			cfgen <= cfgw;
		end
	end

	// Divide pin is transparent while the window is open
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			divide <= 1'b0;
		end else if (cfgw) begin
			divide <= cfg_divide;
		end
	end

	// Oscillator halved
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pclk2 <= 1'b0;
		end else if (osc_rise) begin
			pclk2 <= ~pclk2;
		end
	end

	// Raw or halved oscillator as the processor clock
	assign pclkout = divide ? pclk2 : pclkosc;

	// CPU clock is pclkout halved, sampled like any slow input
	always_ff @(posedge sys_clk) begin
		pout_q <= pclkout;
		pout_qq <= pout_q;
	end
	assign pout_rise = pout_q & ~pout_qq;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cpuclk <= 1'b0;
		end else if (pout_rise) begin
			cpuclk <= ~cpuclk;
		end
	end

endmodule

//--- design/jclk_chroma_div.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chroma divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module jclk_chroma_div (
	input logic sys_clk,
	input logic resetl,
	input logic chrin,
	input jclk_pkg::div6_t chr_div,
	output logic chrdiv
);

	logic chr_q;
	logic chr_qq;
	logic chr_rise;
	logic chr_fall;
	jclk_pkg::div6_t cd;
	jclk_pkg::div6_t half;
	logic q;
	logic extra;

	// Both edges of the chroma clock from two sample stages
	always_ff @(posedge sys_clk) begin
		chr_q <= chrin;
		chr_qq <= chr_q;
	end
	assign chr_rise = chr_q & ~chr_qq;
	assign chr_fall = ~chr_q & chr_qq;

	// Half the divisor, rounded down
	assign half = {1'b0, chr_div[5:1]};

	// Rising edges: reload counter and high phase compare
	// Compare uses the count before this edge's update
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cd <= '0;
			q <= 1'b0;
		end else if (chr_rise) begin
			if (cd == '0) begin
				cd <= chr_div;
			end else begin
				cd <= cd - 1'b1;
			end
			q <= (cd > half);
		end
	end

	// Falling edges: hold the output half a chrin period longer
	// Only for even divisors, i.e. an odd number of chrin periods
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			extra <= 1'b0;
		end else if (chr_fall) begin
			extra <= ~chr_div[0] & q;
		end
	end

	assign chrdiv = q | extra;

endmodule

//--- design/jclk_count_div.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reloading clock divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module jclk_count_div #(
	parameter int WIDTH = 10
) (
	input logic sys_clk,
	input logic resetl,
	input logic clk_in,
	input logic [WIDTH-1:0] divisor,
	output logic div
);

	logic in_q;
	logic in_qq;
	logic in_rise;
	logic [WIDTH-1:0] count;
	logic count_zero;

	// Slow clock sampled twice, rising edge from the two stages
	always_ff @(posedge sys_clk) begin
		in_q <= clk_in;
		in_qq <= in_q;
	end
	assign in_rise = in_q & ~in_qq;

	// Terminal count of the down-counter
	assign count_zero = (count == '0);

	// Down-counter, reload from the divisor at zero
	// Gives divisor+1 input periods per output period
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			count <= '0;
		end else if (in_rise) begin
			if (count_zero) begin
				count <= divisor;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Output high for the one input period after the zero count
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			div <= 1'b0;
		end else if (in_rise) begin
			div <= count_zero;
		end
	end

endmodule

//--- design/jclk_div_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divisor registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "jclk_defines.svh"

module jclk_div_regs (
	input logic sys_clk,
	input logic resetl,
	input jclk_pkg::reg_wr_t bus_wr,
	output jclk_pkg::div10_t pclk_div,
	output jclk_pkg::div10_t vclk_div,
	output jclk_pkg::div6_t chr_div,
	output logic vclk_en
);

	logic pclk_we;
	logic vclk_we;
	logic chr_we;

	// Address decode into one strobe per register
	// Address 0 decodes to nothing
	assign pclk_we = bus_wr.valid && (bus_wr.addr == `JCLK_ADDR_PCLK);
	assign vclk_we = bus_wr.valid && (bus_wr.addr == `JCLK_ADDR_VCLK);
	assign chr_we = bus_wr.valid && (bus_wr.addr == `JCLK_ADDR_CHR);

	// Processor divisor
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pclk_div <= `JCLK_PCLK_RESET;
		end else if (pclk_we) begin
			pclk_div <= bus_wr.data[`JCLK_DIV_W-1:0];
		end
	end

	// Video divisor, stopped at zero until written
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			vclk_div <= '0;
		end else if (vclk_we) begin
			vclk_div <= bus_wr.data[`JCLK_DIV_W-1:0];
		end
	end

	// Chroma divisor
	// Top data bit carries the video enable in the same write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			chr_div <= `JCLK_CHR_RESET;
			vclk_en <= 1'b0;
		end else if (chr_we) begin
			chr_div <= bus_wr.data[`JCLK_CHR_W-1:0];
			vclk_en <= bus_wr.data[15];
		end
	end

endmodule

//--- design/jclk_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock generator types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package jclk_pkg;

	// Processor or video divisor, also the counter value
	typedef logic [9:0] div10_t;

	// Chroma divisor and chroma counter value
	typedef logic [5:0] div6_t;

	// Register select on the shared write bus
	typedef logic [1:0] reg_addr_t;

	// One register write as seen on the bus
	// Valid is held by the master until its grant
	typedef struct packed {
		logic valid;
		reg_addr_t addr;
		logic [15:0] data;
	} reg_wr_t;

	// Owner of the current bus cycle
	// Idle means no write is on the bus
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_HOST,
		ARB_DSP
	} arb_state_t;

endpackage

//--- design/jclk_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock generator top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "jclk_defines.svh"

module jclk_top (
	input logic sys_clk,
	input logic resetl,
	input logic pclkosc,
	input logic vclkin,
	input logic chrin,
	input logic cfg_divide,
	input jclk_pkg::reg_wr_t host_wr,
	input jclk_pkg::reg_wr_t dsp_wr,
	output logic host_gnt,
	output logic dsp_gnt,
	output logic cfgw,
	output logic cfgen,
	output logic pclkout,
	output logic cpuclk,
	output logic pclkdiv,
	output logic vclkdiv,
	output logic chrdiv,
	output logic vclk_en
);

	jclk_pkg::reg_wr_t bus_wr;
	jclk_pkg::div10_t pclk_div;
	jclk_pkg::div10_t vclk_div;
	jclk_pkg::div6_t chr_div;

	// Host and DSP share one register write bus
	jclk_bus_arbiter u_arbiter (
		.sys_clk (sys_clk),
		.resetl (resetl),
		.host_wr (host_wr),
		.dsp_wr (dsp_wr),
		.host_gnt (host_gnt),
		.dsp_gnt (dsp_gnt),
		.bus_wr (bus_wr)
	);

	jclk_div_regs u_regs (
		.sys_clk (sys_clk),
		.resetl (resetl),
		.bus_wr (bus_wr),
		.pclk_div (pclk_div),
		.vclk_div (vclk_div),
		.chr_div (chr_div),
		.vclk_en (vclk_en)
	);

	// Config window, processor and CPU clocks
	jclk_cfg_seq u_cfg_seq (
		.sys_clk (sys_clk),
		.resetl (resetl),
		.pclkosc (pclkosc),
		.cfg_divide (cfg_divide),
		.cfgw (cfgw),
		.cfgen (cfgen),
		.pclkout (pclkout),
		.cpuclk (cpuclk)
	);

	// Processor divider counts oscillator edges
	jclk_count_div #(
		.WIDTH (`JCLK_DIV_W)
	) u_pclk_div (
		.sys_clk (sys_clk),
		.resetl (resetl),
		.clk_in (pclkosc),
		.divisor (pclk_div),
		.div (pclkdiv)
	);

	// Video divider
	jclk_count_div #(
		.WIDTH (`JCLK_DIV_W)
	) u_vclk_div (
		.sys_clk (sys_clk),
		.resetl (resetl),
		.clk_in (vclkin),
		.divisor (vclk_div),
		.div (vclkdiv)
	);

	jclk_chroma_div u_chroma_div (
		.sys_clk (sys_clk),
		.resetl (resetl),
		.chrin (chrin),
		.chr_div (chr_div),
		.chrdiv (chrdiv)
	);

endmodule

//--- include/jclk_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock generator constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef JCLK_DEFINES_SVH
`define JCLK_DEFINES_SVH

// Processor and video divisor width
`define JCLK_DIV_W 10

// Chroma divisor width
`define JCLK_CHR_W 6

// Register map on the shared write bus
// Address 0 is unused
`define JCLK_ADDR_PCLK 2'd1
`define JCLK_ADDR_VCLK 2'd2
`define JCLK_ADDR_CHR 2'd3

// Divisor values after reset
`define JCLK_PCLK_RESET 10'd1
`define JCLK_CHR_RESET 6'd63

`endif

//--- jclk.f
+incdir+include
design/jclk_pkg.sv
design/jclk_bus_arbiter.sv
design/jclk_div_regs.sv
design/jclk_cfg_seq.sv
design/jclk_count_div.sv
design/jclk_chroma_div.sv
design/jclk_top.sv
testbench/tb_jclk.sv

//--- run_jclk.sh
#!/bin/sh
# Build and run the clock generator testbench with Verilator

LOG=sim_jclk.log

verilator --binary -Wno-fatal --top-module tb_jclk -Mdir obj_jclk -f jclk.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_jclk/Vtb_jclk > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: PASSED" "$LOG"; then
	exit 0
fi
exit 1

//--- testbench/jclk_testdata.txt
# kind master addr data exp_period exp_high (addr and data in hex)
# kind 9 sets half-periods, 0 config, 1 pclk, 2 vclk, 3 chroma, 4 host/DSP overlap
9 0 4 5 4 0
0 0 0 1 2 0
0 0 0 0 1 0
1 0 0 0 2 0
1 0 1 005 6 0
1 0 1 00c 13 0
2 1 2 003 4 0
2 1 2 007 8 0
3 0 3 8005 6 6
3 1 3 0006 7 7
3 0 3 0009 10 10
3 1 3 8002 3 3
4 0 1 004 5 6
4 0 1 002 3 9

//--- testbench/tb_jclk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock generator testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_jclk;
	timeunit 1ns;
	timeprecision 100ps;

	logic sys_clk = 1'b0;
	logic resetl = 1'b0;
	logic pclkosc = 1'b0;
	logic vclkin = 1'b0;
	logic chrin = 1'b0;
	logic cfg_divide = 1'b0;
	jclk_pkg::reg_wr_t host_wr = '0;
	jclk_pkg::reg_wr_t dsp_wr = '0;
	logic host_gnt, dsp_gnt, cfgw, cfgen, pclkout, cpuclk;
	logic pclkdiv, vclkdiv, chrdiv, vclk_en;

	// Slow clock half-periods in sys_clk cycles
	int pclk_half = 4;
	int vclk_half = 5;
	int chr_half = 4;
	// Edge counters for pclkosc, vclkin and chrin rises, chrin toggles and pclkout rises
	int cnt [5] = '{0, 0, 0, 0, 0};
	int host_gnts = 0;
	int dsp_gnts = 0;
	// Time of the latest grant pulse of each master
	time host_gnt_t = 0;
	time dsp_gnt_t = 0;
	int errs = 0;
	int seed = 77;
	longint limit_ns = 0;

	jclk_top DUT (.*);

	always #20 sys_clk = ~sys_clk;

	// Oscillators move 2 ns after the sys_clk edge like every other input
	always begin
		repeat (pclk_half) @(posedge sys_clk);
		#2 pclkosc = ~pclkosc;
		if (pclkosc) cnt[0]++;
	end
	always begin
		repeat (vclk_half) @(posedge sys_clk);
		#2 vclkin = ~vclkin;
		if (vclkin) cnt[1]++;
	end
	always begin
		repeat (chr_half) @(posedge sys_clk);
		#2 chrin = ~chrin;
		cnt[3]++;
		if (chrin) cnt[2]++;
	end
	always @(posedge pclkout) cnt[4]++;

	// Every grant pulse must belong to a held request
	always @(negedge sys_clk) begin
		if (resetl && host_gnt) begin
			host_gnts++;
			host_gnt_t = $time;
			if (!host_wr.valid) begin
				$display("Error at %0t: host grant without a request", $time);
				errs++;
			end
		end
		if (resetl && dsp_gnt) begin
			dsp_gnts++;
			dsp_gnt_t = $time;
			if (!dsp_wr.valid) begin
				$display("Error at %0t: DSP grant without a request", $time);
				errs++;
			end
		end
	end

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			errs++;
		end
	endtask

	task automatic check_div10(input string name, input jclk_pkg::div10_t exp,
			input jclk_pkg::div10_t act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
			errs++;
		end
	endtask

	task automatic check_div6(input string name, input jclk_pkg::div6_t exp,
			input jclk_pkg::div6_t act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
			errs++;
		end
	endtask

	function automatic int max_of(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	function automatic logic sig_of(input int sel);
		case (sel)
			0: return pclkdiv;
			1: return vclkdiv;
			2: return chrdiv;
			3: return pclkout;
			default: return cpuclk;
		endcase
	endfunction

	// Outputs are sampled on the falling sys_clk edge away from the register updates
	task automatic wait_level(input int sel, input logic lvl);
		int n;
		n = 0;
		while (sig_of(sel) !== lvl && n < 3000) begin
			@(negedge sys_clk);
			n++;
		end
		if (n == 3000) begin
			$display("Error at %0t: output %0d never reached %b", $time, sel, lvl);
			errs++;
		end
	endtask

	// Period counts reference edges between output rises
	// High time counts chrin toggles
	// First rise is skipped so the period runs on the new divisor
	task automatic measure(input int sel, input int rc, output int per, output int hi);
		int a;
		int h0;
		wait_level(sel, 1'b0);
		wait_level(sel, 1'b1);
		wait_level(sel, 1'b0);
		wait_level(sel, 1'b1);
		a = cnt[rc];
		h0 = cnt[3];
		wait_level(sel, 1'b0);
		hi = cnt[3] - h0;
		wait_level(sel, 1'b1);
		per = cnt[rc] - a;
	endtask

	task automatic bus_write(input int m, input jclk_pkg::reg_addr_t a, input logic [15:0] d);
		jclk_pkg::reg_wr_t w;
		int n;
		w.valid = 1'b1;
		w.addr = a;
		w.data = d;
		n = 0;
		@(posedge sys_clk);
		#2;
		if (m == 0) host_wr = w;
		else dsp_wr = w;
		do begin
			@(negedge sys_clk);
			n++;
		end while (!(m == 0 ? host_gnt : dsp_gnt) && n < 50);
		if (n == 50) begin
			$display("Error at %0t: write from master %0d was never granted", $time, m);
			errs++;
		end
		@(posedge sys_clk);
		#2;
		if (m == 0) host_wr.valid = 1'b0;
		else dsp_wr.valid = 1'b0;
	endtask

	// Release resetl a few cycles after a pclkosc rise so the edge detector is idle
	task automatic do_reset();
		int e;
		resetl = 1'b0;
		repeat (16) @(posedge sys_clk);
		e = cnt[0];
		while (cnt[0] == e) @(posedge sys_clk);
		repeat (3) @(posedge sys_clk);
		#2 resetl = 1'b1;
	endtask

	task automatic wait_osc_rise();
		int e;
		e = cnt[0];
		while (cnt[0] == e) @(negedge sys_clk);
		repeat (3) @(negedge sys_clk);
	endtask

	int kind [$], mst [$], adr [$], dat [$], e1 [$], e2 [$];

	// Every test gets its periods plus a full chroma reload four times over
	// Each period is taken at the slowest input, then doubled
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Error: timeout, the tests did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int fd, r, k, m, a, d, x, y, per, hi, e0, hg, dg, passed, failed;
		int max_half;
		string line;
		longint total;
		passed = 0;
		failed = 0;
		total = 0;
		max_half = max_of(pclk_half, max_of(vclk_half, chr_half));
		fd = $fopen("testbench/jclk_testdata.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open the test data file");
			errs++;
		end else begin
			while (!$feof(fd)) begin
				r = $fgets(line, fd);
				if (r > 0 && line.len() > 1 && line[0] != "#") begin
					if ($sscanf(line, "%d %d %h %h %d %d", k, m, a, d, x, y) == 6) begin
						kind.push_back(k);
						mst.push_back(m);
						adr.push_back(a);
						dat.push_back(d);
						e1.push_back(x);
						e2.push_back(y);
						total += (x + 66) * 4;
						// Half-period lines set the slowest input
						if (k == 9) begin
							max_half = max_of(max_half, max_of(a, max_of(d, x)));
						end
					end
				end
			end
			$fclose(fd);
		end
		limit_ns = total * max_half * 2 * 40 * 2 + 1;
		for (int t = 0; t < kind.size(); t++) begin
			e0 = errs;
			case (kind[t])
				9: begin
					pclk_half = adr[t];
					vclk_half = dat[t];
					chr_half = e1[t];
				end
				0: begin
					@(posedge sys_clk);
					#2 cfg_divide = dat[t][0];
					do_reset();
					@(negedge sys_clk);
					check_bit("cfgw", 1'b0, cfgw);
					check_bit("cfgen", 1'b0, cfgen);
					wait_osc_rise();
					check_bit("cfgw", 1'b1, cfgw);
					check_bit("cfgen", 1'b0, cfgen);
					wait_osc_rise();
					check_bit("cfgen", 1'b1, cfgen);
					measure(3, 0, per, hi);
					check_div10("pclkout period", jclk_pkg::div10_t'(e1[t]),
						jclk_pkg::div10_t'(per));
					measure(4, 4, per, hi);
					check_div10("cpuclk period", 10'd2, jclk_pkg::div10_t'(per));
				end
				1, 2, 3: begin
					if (adr[t] != 0) bus_write(mst[t], adr[t][1:0], dat[t][15:0]);
					measure(kind[t] - 1, kind[t] - 1, per, hi);
					if (kind[t] == 3) begin
						check_div6("chrdiv period", jclk_pkg::div6_t'(e1[t]),
							jclk_pkg::div6_t'(per));
						check_div6("chrdiv high", jclk_pkg::div6_t'(e2[t]),
							jclk_pkg::div6_t'(hi));
						check_bit("vclk_en", dat[t][15], vclk_en);
					end else begin
						check_div10(kind[t] == 1 ? "pclkdiv period" : "vclkdiv period",
							jclk_pkg::div10_t'(e1[t]), jclk_pkg::div10_t'(per));
					end
				end
				default: begin
					// DSP request starts zero or one cycle after the host request
					hg = host_gnts;
					dg = dsp_gnts;
					x = {$random(seed)} % 2;
					fork
						bus_write(0, adr[t][1:0], dat[t][15:0]);
						begin
							repeat (x) @(posedge sys_clk);
							bus_write(1, 2'd2, e2[t][15:0]);
						end
					join
					// Let a repeated grant show up before counting
					repeat (2) @(negedge sys_clk);
					check_bit("host_gnt once", 1'b1, host_gnts - hg == 1);
					check_bit("dsp_gnt once", 1'b1, dsp_gnts - dg == 1);
					check_bit("host_gnt first", 1'b1, host_gnt_t < dsp_gnt_t);
					measure(0, 0, per, hi);
					check_div10("pclkdiv period", jclk_pkg::div10_t'(e1[t]),
						jclk_pkg::div10_t'(per));
					measure(1, 1, per, hi);
					check_div10("vclkdiv period", jclk_pkg::div10_t'(e2[t] + 1),
						jclk_pkg::div10_t'(per));
				end
			endcase
			if (errs == e0) begin
				passed++;
				$display("test %0d kind %0d: pass", t, kind[t]);
			end else begin
				failed++;
				$display("test %0d kind %0d: fail", t, kind[t]);
			end
		end
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errs);
		if (errs == 0 && kind.size() > 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
